//--- verilog/fpsu_pkg.sv
// Packed SIMD unit shared definitions.
// Covers the forwarded word layout, opcodes, type tags and return word bits.

`default_nettype none

package fpsu_pkg;

  // forwarding network
  localparam int NUM_BUSES = 10;

  // parity bit position in a forwarded word, covers everything below it
  localparam int PAR_BIT = 68;

  // 69 reserved, 68 parity, 67..66 tag, 65..64 zero, 63..0 payload
  typedef logic [69:0] bus_word_t;

  typedef bus_word_t [NUM_BUSES-1:0] bus_array_t;

  // values at or above NUM_BUSES select no bus
  typedef logic [3:0] fwd_sel_t;

  typedef logic [7:0] op_t;

  typedef logic [13:0] ret_t;

  typedef enum logic [1:0] {
    NONE  = 2'd0,
    PERM  = 2'd1,
    LOGIC = 2'd2
  } unit_sel_t;

  // permute opcodes
  localparam op_t OP_PERM_COPY = 8'h10;
  localparam op_t OP_PERM_SWAP = 8'h11;
  localparam op_t OP_PERM_DUP  = 8'h12;
  localparam op_t OP_PERM_CMB  = 8'h13;

  // logic group, low two bits pick the operation
  localparam op_t OP_LOGIC = 8'h20;

  // permute unit modes
  localparam logic [1:0] PERM_COPY = 2'd0;
  localparam logic [1:0] PERM_SWAP = 2'd1;
  localparam logic [1:0] PERM_DUP  = 2'd2;
  localparam logic [1:0] PERM_CMB  = 2'd3;

  // logic unit selects
  localparam logic [1:0] LOGIC_AND  = 2'd0;
  localparam logic [1:0] LOGIC_OR   = 2'd1;
  localparam logic [1:0] LOGIC_XOR  = 2'd2;
  localparam logic [1:0] LOGIC_ANDN = 2'd3;

  // result type tags
  localparam logic [1:0] PTYPE_SNGL = 2'b01;
  localparam logic [1:0] PTYPE_INT  = 2'b10;

  // return word bits
  localparam int RET_DONE    = 0;
  localparam int RET_PARITY  = 1;
  localparam int RET_ILLEGAL = 2;

endpackage

`default_nettype wire

//--- verilog/operand_forward.sv
// Operand resolution through the forwarding network.
// Picks a live bus, a one-cycle-old bus or the register file word,
// then registers it along with its parity check.

`timescale 1ns/1ps
`default_nettype none

module operand_forward (
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   en,
  input  wire fpsu_pkg::bus_word_t  rf_word,
  input  wire fpsu_pkg::fwd_sel_t   fwd_now,
  input  wire fpsu_pkg::fwd_sel_t   fwd_old,
  input  wire fpsu_pkg::bus_array_t buses,
  output fpsu_pkg::bus_word_t       operand,
  output logic                      parity_err
);

  fpsu_pkg::bus_array_t buses_d;
  fpsu_pkg::bus_word_t  sel_word;

  // bus history, one cycle deep
  always_ff @(posedge clk) begin
    buses_d <= buses;
  end

  // live select wins over the delayed one
  always_comb begin
    if (fwd_now < fpsu_pkg::NUM_BUSES) begin
      sel_word = buses[fwd_now];
    end else if (fwd_old < fpsu_pkg::NUM_BUSES) begin
      sel_word = buses_d[fwd_old];
    end else begin
      sel_word = rf_word;
    end
  end

  always_ff @(posedge clk) begin
    if (en) begin
      operand <= sel_word;
    end
  end

  // even parity, a set reduction means a flipped bit
  always_ff @(posedge clk) begin
    if (rst) begin
      parity_err <= 1'b0;
    end else if (en) begin
      parity_err <= ^sel_word[fpsu_pkg::PAR_BIT:0];
    end
  end

endmodule

`default_nettype wire

//--- verilog/op_decode.sv
// Opcode decode for the SIMD unit.
// Registers the issue strobe and opcode, then classifies the opcode
// into a unit select and that unit's control field.

`timescale 1ns/1ps
`default_nettype none

module op_decode (
  input  wire                 clk,
  input  wire                 rst,
  input  wire                 en,
  input  wire fpsu_pkg::op_t  op,
  output logic                issued,
  output fpsu_pkg::unit_sel_t unit,
  output logic [1:0]          perm_mode,
  output logic [1:0]          logic_sel,
  output logic                illegal
);

  logic          en_reg;
  fpsu_pkg::op_t op_reg;
  logic          known;

  always_ff @(posedge clk) begin
    if (rst) begin
      en_reg <= 1'b0;
    end else begin
      en_reg <= en;
    end
  end

  always_ff @(posedge clk) begin
    if (en) begin
      op_reg <= op;
    end
  end

  always_comb begin
    unit      = fpsu_pkg::NONE;
    perm_mode = fpsu_pkg::PERM_COPY;
    logic_sel = op_reg[1:0];
    known     = 1'b1;
    case (op_reg)
      fpsu_pkg::OP_PERM_COPY: begin
        unit      = fpsu_pkg::PERM;
        perm_mode = fpsu_pkg::PERM_COPY;
      end
      fpsu_pkg::OP_PERM_SWAP: begin
        unit      = fpsu_pkg::PERM;
        perm_mode = fpsu_pkg::PERM_SWAP;
      end
      fpsu_pkg::OP_PERM_DUP: begin
        unit      = fpsu_pkg::PERM;
        perm_mode = fpsu_pkg::PERM_DUP;
      end
      fpsu_pkg::OP_PERM_CMB: begin
        unit      = fpsu_pkg::PERM;
        perm_mode = fpsu_pkg::PERM_CMB;
      end
      default: begin
        // whole logic group shares the top six bits
        if (op_reg[7:2] == fpsu_pkg::OP_LOGIC[7:2]) begin
          unit = fpsu_pkg::LOGIC;
        end else begin
          known = 1'b0;
        end
      end
    endcase
  end

  assign issued  = en_reg;
  assign illegal = en_reg & ~known;

endmodule

`default_nettype wire

//--- verilog/perm_unit.sv
// Permute unit working on packed 32-bit halves.
// Copy, swap, duplicate low, or combine A high with B low.

`timescale 1ns/1ps
`default_nettype none

module perm_unit (
  input  wire                      clk,
  input  wire                      rst,
  input  wire                      go,
  input  wire [1:0]                perm_mode,
  input  wire fpsu_pkg::bus_word_t a,
  input  wire fpsu_pkg::bus_word_t b,
  output logic                     valid,
  output logic [63:0]              payload
);

  logic [31:0] a_hi;
  logic [31:0] a_lo;
  logic [31:0] b_lo;
  logic [63:0] perm_res;

  assign a_hi = a[63:32];
  assign a_lo = a[31:0];
  assign b_lo = b[31:0];

  always_comb begin
    case (perm_mode)
      fpsu_pkg::PERM_SWAP: perm_res = {a_lo, a_hi};
      fpsu_pkg::PERM_DUP:  perm_res = {a_lo, a_lo};
      fpsu_pkg::PERM_CMB:  perm_res = {a_hi, b_lo};
      default:             perm_res = {a_hi, a_lo};
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= 1'b0;
    end else begin
      valid <= go;
    end
  end

  always_ff @(posedge clk) begin
    if (go) begin
      payload <= perm_res;
    end
  end

endmodule

`default_nettype wire

//--- verilog/logic_unit.sv
// 64-bit bitwise logic unit.
// AND, OR, XOR and A AND NOT B on the operand payloads.

`timescale 1ns/1ps
`default_nettype none

module logic_unit (
  input  wire                      clk,
  input  wire                      rst,
  input  wire                      go,
  input  wire [1:0]                logic_sel,
  input  wire fpsu_pkg::bus_word_t a,
  input  wire fpsu_pkg::bus_word_t b,
  output logic                     valid,
  output logic [63:0]              payload
);

  logic [63:0] logic_res;

  always_comb begin
    case (logic_sel)
      fpsu_pkg::LOGIC_OR:   logic_res = a[63:0] | b[63:0];
      fpsu_pkg::LOGIC_XOR:  logic_res = a[63:0] ^ b[63:0];
      fpsu_pkg::LOGIC_ANDN: logic_res = a[63:0] & ~b[63:0];
      default:              logic_res = a[63:0] & b[63:0];
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= 1'b0;
    end else begin
      valid <= go;
    end
  end

  always_ff @(posedge clk) begin
    if (go) begin
      payload <= logic_res;
    end
  end

endmodule

`default_nettype wire

//--- verilog/result_writeback.sv
// Result writeback stage.
// Merges the unit results into a tagged, parity-protected word
// and builds the completion/exception return word.

`timescale 1ns/1ps
`default_nettype none

module result_writeback (
  input  wire                 clk,
  input  wire                 rst,
  input  wire                 perm_valid,
  input  wire [63:0]          perm_payload,
  input  wire                 logic_valid,
  input  wire [63:0]          logic_payload,
  input  wire                 issued_d,
  input  wire                 err_d,
  input  wire                 illegal_d,
  output fpsu_pkg::bus_word_t result,
  output logic                result_valid,
  output fpsu_pkg::ret_t      ret,
  output logic                ret_en
);

  logic [67:0]    body;
  fpsu_pkg::ret_t ret_word;

  // tag, two zero bits, payload
  always_comb begin
    if (perm_valid) begin
      body = {fpsu_pkg::PTYPE_SNGL, 2'b00, perm_payload};
    end else begin
      body = {fpsu_pkg::PTYPE_INT, 2'b00, logic_payload};
    end
  end

  always_comb begin
    ret_word                        = '0;
    ret_word[fpsu_pkg::RET_DONE]    = 1'b1;
    ret_word[fpsu_pkg::RET_PARITY]  = err_d;
    ret_word[fpsu_pkg::RET_ILLEGAL] = illegal_d;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      result_valid <= 1'b0;
      result       <= '0;
      ret_en       <= 1'b0;
      ret          <= '0;
    end else begin
      result_valid <= perm_valid | logic_valid;
      ret_en       <= issued_d;
      if (perm_valid | logic_valid) begin
        result <= {1'b0, ^body, body};
      end else begin
        result <= '0;
      end
      ret <= issued_d ? ret_word : '0;
    end
  end

endmodule

`default_nettype wire

//--- verilog/fpsu_top.sv
// Packed-operand SIMD unit top level.
// Forwards both operands, decodes the opcode, runs the permute or
// logic unit and returns a result word plus a return word, 3 cycles
// after issue.

`timescale 1ns/1ps
`default_nettype none

module fpsu_top (
  input  wire                       clk,
  input  wire                       rst,
  input  wire                       en,
  input  wire fpsu_pkg::op_t        op,
  input  wire fpsu_pkg::bus_word_t  rf_a,
  input  wire fpsu_pkg::bus_word_t  rf_b,
  input  wire fpsu_pkg::fwd_sel_t   fwd_now_a,
  input  wire fpsu_pkg::fwd_sel_t   fwd_old_a,
  input  wire fpsu_pkg::fwd_sel_t   fwd_now_b,
  input  wire fpsu_pkg::fwd_sel_t   fwd_old_b,
  input  wire fpsu_pkg::bus_array_t buses,
  output fpsu_pkg::bus_word_t       result,
  output logic                      result_valid,
  output fpsu_pkg::ret_t            ret,
  output logic                      ret_en
);

  fpsu_pkg::bus_word_t opnd_a;
  fpsu_pkg::bus_word_t opnd_b;
  logic                err_a;
  logic                err_b;
  logic                issued;
  fpsu_pkg::unit_sel_t unit;
  logic [1:0]          perm_mode;
  logic [1:0]          logic_sel;
  logic                illegal;
  logic                op_err;
  logic                perm_go;
  logic                logic_go;
  logic                perm_valid;
  logic [63:0]         perm_payload;
  logic                logic_valid;
  logic [63:0]         logic_payload;
  logic                issued_d;
  logic                err_d;
  logic                illegal_d;

  operand_forward fwd_a (
    .clk        (clk),
    .rst        (rst),
    .en         (en),
    .rf_word    (rf_a),
    .fwd_now    (fwd_now_a),
    .fwd_old    (fwd_old_a),
    .buses      (buses),
    .operand    (opnd_a),
    .parity_err (err_a)
  );

  operand_forward fwd_b (
    .clk        (clk),
    .rst        (rst),
    .en         (en),
    .rf_word    (rf_b),
    .fwd_now    (fwd_now_b),
    .fwd_old    (fwd_old_b),
    .buses      (buses),
    .operand    (opnd_b),
    .parity_err (err_b)
  );

  op_decode dec (
    .clk       (clk),
    .rst       (rst),
    .en        (en),
    .op        (op),
    .issued    (issued),
    .unit      (unit),
    .perm_mode (perm_mode),
    .logic_sel (logic_sel),
    .illegal   (illegal)
  );

  // a bad operand keeps both units idle
  assign op_err   = err_a | err_b;
  assign perm_go  = issued & (unit == fpsu_pkg::PERM) & ~op_err;
  assign logic_go = issued & (unit == fpsu_pkg::LOGIC) & ~op_err;

  perm_unit perm (
    .clk       (clk),
    .rst       (rst),
    .go        (perm_go),
    .perm_mode (perm_mode),
    .a         (opnd_a),
    .b         (opnd_b),
    .valid     (perm_valid),
    .payload   (perm_payload)
  );

  logic_unit lgc (
    .clk       (clk),
    .rst       (rst),
    .go        (logic_go),
    .logic_sel (logic_sel),
    .a         (opnd_a),
    .b         (opnd_b),
    .valid     (logic_valid),
    .payload   (logic_payload)
  );

  // status follows the units by one stage
  always_ff @(posedge clk) begin
    if (rst) begin
      issued_d <= 1'b0;
    end else begin
      issued_d <= issued;
    end
  end

  always_ff @(posedge clk) begin
    err_d     <= issued & op_err;
    illegal_d <= illegal;
  end

  result_writeback wb (
    .clk           (clk),
    .rst           (rst),
    .perm_valid    (perm_valid),
    .perm_payload  (perm_payload),
    .logic_valid   (logic_valid),
    .logic_payload (logic_payload),
    .issued_d      (issued_d),
    .err_d         (err_d),
    .illegal_d     (illegal_d),
    .result        (result),
    .result_valid  (result_valid),
    .ret           (ret),
    .ret_en        (ret_en)
  );

endmodule

`default_nettype wire

//--- verif/fpsu_assertions.sv
// Concurrent checks on the SIMD unit outputs.
// Bound into the top level.

`timescale 1ns/1ps
`default_nettype none

module fpsu_assertions (
  input wire                      clk,
  input wire                      rst,
  input wire fpsu_pkg::bus_word_t result,
  input wire                      result_valid,
  input wire                      ret_en
);

  // a result always comes with its return word
  valid_has_ret: assert property (
    @(posedge clk) disable iff (rst) result_valid |-> ret_en
  ) else $error("result_valid without ret_en");

  // even parity over everything below and including the parity bit
  result_parity: assert property (
    @(posedge clk) disable iff (rst) result_valid |-> !(^result[fpsu_pkg::PAR_BIT:0])
  ) else $error("result parity is wrong");

  // once reset has been seen for a cycle the outputs are quiet
  quiet_in_reset: assert property (
    @(posedge clk) (rst && $past(rst)) |-> (!result_valid && !ret_en)
  ) else $error("outputs active during reset");

endmodule

bind fpsu_top fpsu_assertions chk (
  .clk          (clk),
  .rst          (rst),
  .result       (result),
  .result_valid (result_valid),
  .ret_en       (ret_en)
);

`default_nettype wire

//--- include/fpsu_tb_model.svh
// Reference model for the SIMD unit.
// Operand resolution, execution result and return word as functions.

`ifndef FPSU_TB_MODEL_SVH
`define FPSU_TB_MODEL_SVH

function automatic fpsu_pkg::bus_word_t model_operand(
  input fpsu_pkg::bus_word_t  rf,
  input fpsu_pkg::fwd_sel_t   now_sel,
  input fpsu_pkg::fwd_sel_t   old_sel,
  input fpsu_pkg::bus_array_t bus_now,
  input fpsu_pkg::bus_array_t bus_old
);
  if (now_sel < fpsu_pkg::NUM_BUSES) return bus_now[now_sel];
  if (old_sel < fpsu_pkg::NUM_BUSES) return bus_old[old_sel];
  return rf;
endfunction

function automatic logic model_parity_err(input fpsu_pkg::bus_word_t w);
  return ^w[fpsu_pkg::PAR_BIT:0];
endfunction

function automatic logic model_illegal(input fpsu_pkg::op_t op);
  if (op >= fpsu_pkg::OP_PERM_COPY && op <= fpsu_pkg::OP_PERM_CMB) return 1'b0;
  return op[7:2] != fpsu_pkg::OP_LOGIC[7:2];
endfunction

// zero word when the unit stays idle
function automatic fpsu_pkg::bus_word_t model_result(
  input fpsu_pkg::op_t       op,
  input fpsu_pkg::bus_word_t a,
  input fpsu_pkg::bus_word_t b
);
  logic [63:0] pl;
  logic [1:0]  tag;
  logic [67:0] body;
  tag = (op[7:2] == fpsu_pkg::OP_LOGIC[7:2]) ? fpsu_pkg::PTYPE_INT : fpsu_pkg::PTYPE_SNGL;
  case (op)
    fpsu_pkg::OP_PERM_COPY: pl = a[63:0];
    fpsu_pkg::OP_PERM_SWAP: pl = {a[31:0], a[63:32]};
    fpsu_pkg::OP_PERM_DUP:  pl = {a[31:0], a[31:0]};
    fpsu_pkg::OP_PERM_CMB:  pl = {a[63:32], b[31:0]};
    default: begin
      case (op[1:0])
        fpsu_pkg::LOGIC_AND: pl = a[63:0] & b[63:0];
        fpsu_pkg::LOGIC_OR:  pl = a[63:0] | b[63:0];
        fpsu_pkg::LOGIC_XOR: pl = a[63:0] ^ b[63:0];
        default:             pl = a[63:0] & ~b[63:0];
      endcase
    end
  endcase
  body = {tag, 2'b00, pl};
  if (model_illegal(op) || model_parity_err(a) || model_parity_err(b)) return '0;
  return {1'b0, ^body, body};
endfunction

function automatic fpsu_pkg::ret_t model_ret(input logic err, input logic illegal);
  fpsu_pkg::ret_t r;
  r                        = '0;
  r[fpsu_pkg::RET_DONE]    = 1'b1;
  r[fpsu_pkg::RET_PARITY]  = err;
  r[fpsu_pkg::RET_ILLEGAL] = illegal;
  return r;
endfunction

`endif

//--- verif/fpsu_tb.sv
// Testbench for the packed SIMD unit.
// Random issue stream through the forwarding network, checked
// against the reference model with a queue of expected responses.

`timescale 1ns/1ps
`default_nettype none

module fpsu_tb;

  `include "fpsu_tb_model.svh"

  logic                 clk;
  logic                 rst;
  logic                 en;
  fpsu_pkg::op_t        op;
  fpsu_pkg::bus_word_t  rf_a;
  fpsu_pkg::bus_word_t  rf_b;
  fpsu_pkg::fwd_sel_t   fwd_now_a;
  fpsu_pkg::fwd_sel_t   fwd_old_a;
  fpsu_pkg::fwd_sel_t   fwd_now_b;
  fpsu_pkg::fwd_sel_t   fwd_old_b;
  fpsu_pkg::bus_array_t buses;
  fpsu_pkg::bus_word_t  result;
  logic                 result_valid;
  fpsu_pkg::ret_t       ret;
  logic                 ret_en;

  // bus values driven this cycle and the cycle before
  fpsu_pkg::bus_array_t bus_cur;
  fpsu_pkg::bus_array_t bus_prev;
  logic [7:0]           flip_odds;

  // expected responses in issue order
  string                name_q[$];
  fpsu_pkg::bus_word_t  word_q[$];
  logic                 valid_q[$];
  fpsu_pkg::ret_t       ret_q[$];
  int                   due_q[$];

  int          neg_cnt;
  int          checks;
  int          errors;
  int          test_err;
  int          test_ops;
  int          test_cnt;

  fpsu_top UUT (
    .clk          (clk),
    .rst          (rst),
    .en           (en),
    .op           (op),
    .rf_a         (rf_a),
    .rf_b         (rf_b),
    .fwd_now_a    (fwd_now_a),
    .fwd_old_a    (fwd_old_a),
    .fwd_now_b    (fwd_now_b),
    .fwd_old_b    (fwd_old_b),
    .buses        (buses),
    .result       (result),
    .result_valid (result_valid),
    .ret          (ret),
    .ret_en       (ret_en)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // random payload and tag with an occasional parity flip
  function automatic fpsu_pkg::bus_word_t rand_word(input logic [7:0] odds);
    logic [31:0] r;
    logic [63:0] pl;
    logic [67:0] body;
    logic        flip;
    r    = $urandom;
    pl   = {$urandom, $urandom};
    body = {(r[8] ? fpsu_pkg::PTYPE_INT : fpsu_pkg::PTYPE_SNGL), 2'b00, pl};
    flip = ((r[7:0] & odds) == 8'd0);
    rand_word = {1'b0, (^body) ^ flip, body};
  endfunction

  // mode 0 permute, 1 logic, 2 forwarding, 3 exceptions, 4 mixed
  function automatic fpsu_pkg::op_t pick_op(input int mode);
    logic [31:0]   r;
    fpsu_pkg::op_t perm_op;
    fpsu_pkg::op_t logic_op;
    r        = $urandom;
    perm_op  = {fpsu_pkg::OP_PERM_COPY[7:2], r[1:0]};
    logic_op = {fpsu_pkg::OP_LOGIC[7:2], r[1:0]};
    case (mode)
      0:       pick_op = perm_op;
      1:       pick_op = logic_op;
      default: pick_op = r[2] ? perm_op : logic_op;
    endcase
    if ((mode == 3 && r[9:8] == 2'd0) || (mode == 4 && r[11:9] == 3'd0)) begin
      pick_op = r[31:24];
    end
  endfunction

  task automatic report_error(input string msg);
    $display("%s", msg);
    errors++;
    test_err++;
  endtask

  task automatic compare_word(input string name, input fpsu_pkg::bus_word_t exp,
                              input fpsu_pkg::bus_word_t act);
    checks++;
    if (act !== exp) begin
      report_error($sformatf("Mismatch %s result: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic compare_ret(input string name, input fpsu_pkg::ret_t exp,
                             input fpsu_pkg::ret_t act);
    checks++;
    if (act !== exp) begin
      report_error($sformatf("Mismatch %s ret: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic compare_flag(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      report_error($sformatf("Mismatch %s result_valid: expected %b, actual %b",
                             name, exp, act));
    end
  endtask

  // drives one cycle and queues the expected response on an issue
  task automatic drive_cycle(input string name, input int mode, input logic idle);
    fpsu_pkg::bus_array_t nb;
    fpsu_pkg::bus_word_t  ra;
    fpsu_pkg::bus_word_t  rb;
    fpsu_pkg::bus_word_t  opa;
    fpsu_pkg::bus_word_t  opb;
    fpsu_pkg::fwd_sel_t   na;
    fpsu_pkg::fwd_sel_t   nbs;
    fpsu_pkg::fwd_sel_t   idx;
    fpsu_pkg::op_t        o;
    logic [31:0]          r;
    logic                 issue;
    logic                 bad;
    @(posedge clk);
    bus_prev = bus_cur;
    for (idx = 4'd0; idx < fpsu_pkg::NUM_BUSES; idx++) begin
      nb[idx] = rand_word(flip_odds);
    end
    bus_cur = nb;
    ra      = rand_word(flip_odds);
    rb      = rand_word(flip_odds);
    o       = pick_op(mode);
    r       = $urandom;
    issue   = !idle && (mode == 2 || r[1:0] != 2'b00);
    na      = r[7:4];
    nbs     = r[15:12];
    // forwarding runs push the delayed path harder
    if (mode == 2 && r[2]) begin
      na = 4'hf;
    end
    if (mode == 2 && r[3]) begin
      nbs = 4'hf;
    end
    en        <= issue;
    op        <= o;
    rf_a      <= ra;
    rf_b      <= rb;
    fwd_now_a <= na;
    fwd_old_a <= r[11:8];
    fwd_now_b <= nbs;
    fwd_old_b <= r[19:16];
    buses     <= nb;
    if (issue) begin
      opa = model_operand(ra, na, r[11:8], nb, bus_prev);
      opb = model_operand(rb, nbs, r[19:16], nb, bus_prev);
      bad = model_parity_err(opa) || model_parity_err(opb);
      name_q.push_back(name);
      word_q.push_back(model_result(o, opa, opb));
      valid_q.push_back(!bad && !model_illegal(o));
      ret_q.push_back(model_ret(bad, model_illegal(o)));
      due_q.push_back(neg_cnt + 4);
      test_ops++;
    end
  endtask

  task automatic check_outputs();
    string               name;
    int                  due;
    logic                exp_valid;
    fpsu_pkg::bus_word_t exp_word;
    fpsu_pkg::ret_t      exp_ret;
    if (result_valid && !ret_en) begin
      report_error("result_valid went high without ret_en");
    end
    if (ret_en && name_q.size() == 0) begin
      report_error("ret_en pulsed with no operation in flight");
    end else if (ret_en || (due_q.size() != 0 && neg_cnt > due_q[0])) begin
      name      = name_q.pop_front();
      due       = due_q.pop_front();
      exp_valid = valid_q.pop_front();
      exp_word  = word_q.pop_front();
      exp_ret   = ret_q.pop_front();
      if (!ret_en) begin
        report_error($sformatf("%s got no ret_en 3 cycles after issue", name));
      end else begin
        if (neg_cnt != due) begin
          report_error($sformatf("%s returned in cycle %0d, expected cycle %0d",
                                 name, neg_cnt, due));
        end
        compare_flag(name, exp_valid, result_valid);
        compare_word(name, exp_word, result);
        compare_ret(name, exp_ret, ret);
      end
    end
  endtask

  task automatic drain_queue(input string name);
    int waited;
    waited = 0;
    while (name_q.size() != 0 && waited < 20) begin
      drive_cycle(name, 0, 1'b1);
      waited++;
    end
    if (name_q.size() != 0) begin
      report_error($sformatf("timeout in %s, %0d operations never returned",
                             name, name_q.size()));
      name_q.delete();
      word_q.delete();
      valid_q.delete();
      ret_q.delete();
      due_q.delete();
    end
  endtask

  task automatic finish_test(input string name);
    $display("test %s: %0d ops, %0d errors", name, test_ops, test_err);
    test_cnt++;
  endtask

  task automatic run_test(input string name, input int mode, input int n,
                          input logic [7:0] odds);
    int k;
    test_err  = 0;
    test_ops  = 0;
    flip_odds = odds;
    for (k = 0; k < n; k++) begin
      drive_cycle(name, mode, 1'b0);
    end
    drain_queue(name);
    finish_test(name);
  endtask

  // compares each ret_en against the queue head
  initial begin
    neg_cnt = 0;
    forever begin
      @(negedge clk);
      neg_cnt++;
      if (!rst) begin
        check_outputs();
      end
    end
  end

  initial begin
    void'($urandom(32'h49fb));
    checks    = 0;
    errors    = 0;
    test_cnt  = 0;
    test_err  = 0;
    test_ops  = 0;
    flip_odds = 8'hff;
    bus_cur   = '0;
    bus_prev  = '0;
    rst       <= 1'b1;
    en        <= 1'b0;
    op        <= '0;
    rf_a      <= '0;
    rf_b      <= '0;
    fwd_now_a <= 4'hf;
    fwd_old_a <= 4'hf;
    fwd_now_b <= 4'hf;
    fwd_old_b <= 4'hf;
    buses     <= '0;
    repeat (10) begin
      @(negedge clk);
      if (ret_en !== 1'b0 || result_valid !== 1'b0) begin
        report_error("ret_en or result_valid high during reset");
      end
    end
    @(posedge clk);
    rst <= 1'b0;
    repeat (5) begin
      drive_cycle("reset_quiet", 0, 1'b1);
    end
    finish_test("reset_quiet");
    run_test("permute", 0, 60, 8'hff);
    run_test("logic", 1, 60, 8'hff);
    run_test("forwarding", 2, 80, 8'h3f);
    run_test("exceptions", 3, 80, 8'h03);
    run_test("mixed", 4, 200, 8'h3f);
    $display("tests %0d, checks %0d, errors %0d", test_cnt, checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
+incdir+include
verilog/fpsu_pkg.sv
verilog/operand_forward.sv
verilog/op_decode.sv
verilog/perm_unit.sv
verilog/logic_unit.sv
verilog/result_writeback.sv
verilog/fpsu_top.sv
verif/fpsu_assertions.sv
verif/fpsu_tb.sv

//--- run.sh
#!/bin/sh
# build and run the SIMD unit testbench with Verilator
cd "$(dirname "$0")" &&
  verilator --binary --assert --timescale 1ns/1ps --top-module fpsu_tb -f all.f &&
  ./obj_dir/Vfpsu_tb +verilator+error+limit+1000 | tee /dev/stderr | grep -q "^sim passed$" &&
  echo "run.sh: PASS" || { echo "run.sh: FAIL"; exit 1; }
